// File: source/isa_pkg.sv
package isa_pkg;

    // Architectural data width
    localparam int xlen = 32;

    // Unit that executes the micro-op
    typedef enum logic [1:0] {
        unit_alu    = 2'd0,
        unit_branch = 2'd1,
        unit_mul    = 2'd2
    } exec_unit_e;

    // Function codes
    typedef enum logic [4:0] {
        // Integer ALU
        func_add      = 5'd0,
        func_sub      = 5'd1,
        func_sll      = 5'd2,
        func_slt      = 5'd3,
        func_sltu     = 5'd4,
        func_xor      = 5'd5,
        func_srl      = 5'd6,
        func_sra      = 5'd7,
        func_or       = 5'd8,
        func_and      = 5'd9,
        func_pass_op2 = 5'd10,
        // Conditional branches and jumps
        func_beq      = 5'd11,
        func_bne      = 5'd12,
        func_blt      = 5'd13,
        func_bge      = 5'd14,
        func_bltu     = 5'd15,
        func_bgeu     = 5'd16,
        func_jal      = 5'd17,
        func_jalr     = 5'd18,
        // Multiply
        func_mul      = 5'd19,
        func_mulh     = 5'd20,
        func_mulhsu   = 5'd21,
        func_mulhu    = 5'd22
    } func_e;

endpackage

// File: source/uop_pkg.sv
package uop_pkg;

    import isa_pkg::*;

    // First operand source
    typedef enum logic [1:0] {
        op1_rs1  = 2'd0,
        op1_pc   = 2'd1,
        op1_zero = 2'd2
    } op1_sel_e;

    // Second operand source
    typedef enum logic [1:0] {
        op2_rs2  = 2'd0,
        op2_imm  = 2'd1,
        op2_four = 2'd2,
        op2_zero = 2'd3
    } op2_sel_e;

    // Decoded micro-op from decode
    typedef struct packed {
        logic            valid;
        exec_unit_e      unit;
        func_e           func;
        op1_sel_e        op1_sel;
        op2_sel_e        op2_sel;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] pc;
    } uop_t;

    // Registered stage output towards write-back
    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        logic            rd_write;
        logic [xlen-1:0] rd_value;
    } result_t;

endpackage

// File: source/operand_select.sv
module operand_select
    import isa_pkg::*, uop_pkg::*;
(
    input  uop_t            uop,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    input  result_t         prev,
    output logic [xlen-1:0] op1,
    output logic [xlen-1:0] op2
);

    logic [xlen-1:0] rs1_value;
    logic [xlen-1:0] rs2_value;

    // Previous result still in flight, x0 never forwards
    function automatic logic fwd_hit(input logic [4:0] src, input result_t p);
        return p.valid && p.rd_write && (p.rd != 5'd0) && (p.rd == src);
    endfunction

    assign rs1_value = fwd_hit(uop.rs1, prev) ? prev.rd_value : rs1_data;
    assign rs2_value = fwd_hit(uop.rs2, prev) ? prev.rd_value : rs2_data;

    always_comb begin
        case (uop.op1_sel)
            op1_rs1: op1 = rs1_value;
            op1_pc:  op1 = uop.pc;
            default: op1 = '0;
        endcase
    end

    always_comb begin
        case (uop.op2_sel)
            op2_rs2:  op2 = rs2_value;
            op2_imm:  op2 = uop.imm;
            op2_four: op2 = xlen'(4);
            default:  op2 = '0;
        endcase
    end

endmodule

// File: source/alu.sv
module alu
    import isa_pkg::*;
(
    input  func_e           func,
    input  logic [xlen-1:0] op1,
    input  logic [xlen-1:0] op2,
    output logic [xlen-1:0] value
);

    logic [4:0]      shamt;
    logic            lt_signed;
    logic            lt_unsigned;

    assign shamt       = op2[4:0];
    assign lt_signed   = $signed(op1) < $signed(op2);
    assign lt_unsigned = op1 < op2;

    always_comb begin
        case (func)
            func_add:      value = op1 + op2;
            func_sub:      value = op1 - op2;
            func_sll:      value = op1 << shamt;
            func_slt:      value = {{(xlen-1){1'b0}}, lt_signed};
            func_sltu:     value = {{(xlen-1){1'b0}}, lt_unsigned};
            func_xor:      value = op1 ^ op2;
            func_srl:      value = op1 >> shamt;
            func_sra:      value = $unsigned($signed(op1) >>> shamt);
            func_or:       value = op1 | op2;
            func_and:      value = op1 & op2;
            // LUI style, immediate straight through
            func_pass_op2: value = op2;
            default:       value = '0;
        endcase
    end

endmodule

// File: source/branch_unit.sv
module branch_unit
    import isa_pkg::*;
(
    input  func_e           func,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] imm,
    input  logic [xlen-1:0] op1,
    input  logic [xlen-1:0] op2,
    output logic            redirect,
    output logic [xlen-1:0] target,
    output logic [xlen-1:0] link
);

    logic            eq;
    logic            lt_signed;
    logic            lt_unsigned;
    logic [xlen-1:0] jalr_sum;

    assign eq          = op1 == op2;
    assign lt_signed   = $signed(op1) < $signed(op2);
    assign lt_unsigned = op1 < op2;

    ////////////////////////////////////////////////////////////////////////////
    // Condition
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (func)
            func_beq:  redirect = eq;
            func_bne:  redirect = !eq;
            func_blt:  redirect = lt_signed;
            func_bge:  redirect = !lt_signed;
            func_bltu: redirect = lt_unsigned;
            func_bgeu: redirect = !lt_unsigned;
            func_jal,
            func_jalr: redirect = 1'b1;
            default:   redirect = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Target and link
    ////////////////////////////////////////////////////////////////////////////

    // JALR clears bit 0 of the sum
    assign jalr_sum = op1 + imm;
    assign target   = (func == func_jalr) ? {jalr_sum[xlen-1:1], 1'b0} : pc + imm;
    assign link     = pc + xlen'(4);

endmodule

// File: source/multiplier.sv
module multiplier
    import isa_pkg::*;
#(
    parameter int mul_bits_per_cycle = 2
) (
    input  logic            clk_g,
    input  logic            rst_g,
    input  logic            start,
    input  func_e           func,
    input  logic [xlen-1:0] op1,
    input  logic [xlen-1:0] op2,
    output logic            done,
    output logic [xlen-1:0] product
);

    localparam int steps = xlen / mul_bits_per_cycle;
    localparam int cnt_w = $clog2(steps);

    logic              signed1;
    logic              signed2;
    logic              running;
    logic [cnt_w-1:0]  count;
    logic [2*xlen-1:0] mcand;
    logic [xlen-1:0]   mplier;
    logic [2*xlen-1:0] acc;
    logic [2*xlen-1:0] partial;
    logic [2*xlen-1:0] acc_next;
    logic [2*xlen-1:0] full;
    logic              negate;
    logic              high_word;

    assign signed1 = (func == func_mulh) || (func == func_mulhsu);
    assign signed2 = func == func_mulh;

    // Partial products of this step's multiplier bits
    always_comb begin
        partial = '0;
        for (int i = 0; i < mul_bits_per_cycle; i++) begin
            if (mplier[i]) begin
                partial = partial + (mcand << i);
            end
        end
    end

    assign acc_next = acc + partial;

    always_ff @(posedge clk_g) begin
        if (rst_g) begin
            running <= 1'b0;
            count   <= '0;
        end else if (start) begin
            running   <= 1'b1;
            count     <= '0;
            // Magnitudes and result sign
            mcand     <= {{xlen{1'b0}}, (signed1 && op1[xlen-1]) ? -op1 : op1};
            mplier    <= (signed2 && op2[xlen-1]) ? -op2 : op2;
            negate    <= (signed1 && op1[xlen-1]) ^ (signed2 && op2[xlen-1]);
            high_word <= func != func_mul;
            acc       <= '0;
        end else if (running) begin
            count  <= count + 1'b1;
            mcand  <= mcand << mul_bits_per_cycle;
            mplier <= mplier >> mul_bits_per_cycle;
            acc    <= acc_next;
            if (done) begin
                running <= 1'b0;
            end
        end
    end

    // Last step completes combinationally
    assign done    = running && (count == cnt_w'(steps - 1));
    assign full    = negate ? -acc_next : acc_next;
    assign product = high_word ? full[2*xlen-1:xlen] : full[xlen-1:0];

endmodule

// File: source/execute_control.sv
module execute_control
    import isa_pkg::*, uop_pkg::*;
(
    input  logic            clk_g,
    input  logic            rst_g,
    input  uop_t            uop,
    input  logic [xlen-1:0] alu_value,
    input  logic            redirect,
    input  logic [xlen-1:0] target,
    input  logic [xlen-1:0] link,
    input  logic            mul_done,
    input  logic [xlen-1:0] product,
    output logic            mul_start,
    output logic            stall,
    output logic            flush,
    output logic [xlen-1:0] next_pc,
    output logic            exception,
    output logic [xlen-1:0] exception_pc,
    output result_t         result
);

    logic            is_alu;
    logic            is_branch;
    logic            is_mul;
    logic            is_jump;
    logic            misaligned;
    logic            mul_busy;
    logic            rd_write;
    logic [xlen-1:0] rd_value;

    assign is_alu    = uop.valid && (uop.unit == unit_alu);
    assign is_branch = uop.valid && (uop.unit == unit_branch);
    assign is_mul    = uop.valid && (uop.unit == unit_mul);
    assign is_jump   = (uop.func == func_jal) || (uop.func == func_jalr);

    ////////////////////////////////////////////////////////////////////////////
    // Multiply handshake and stall
    ////////////////////////////////////////////////////////////////////////////

    assign mul_start = is_mul && !mul_busy;
    assign stall     = is_mul && !mul_done;

    always_ff @(posedge clk_g) begin
        if (rst_g) begin
            mul_busy <= 1'b0;
        end else if (mul_start) begin
            mul_busy <= 1'b1;
        end else if (mul_done) begin
            mul_busy <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Redirect
    ////////////////////////////////////////////////////////////////////////////

    assign misaligned   = target[1:0] != 2'b00;
    assign flush        = is_branch && redirect;
    // Misaligned target traps, fetch stays at the micro-op's pc
    assign exception    = flush && misaligned;
    assign exception_pc = exception ? target : uop.pc;
    assign next_pc      = (flush && !misaligned) ? target : uop.pc;

    ////////////////////////////////////////////////////////////////////////////
    // Result
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (uop.unit)
            unit_branch: rd_value = link;
            unit_mul:    rd_value = product;
            default:     rd_value = alu_value;
        endcase
    end

    assign rd_write = is_alu || (is_branch && is_jump) || (is_mul && mul_done);

    always_ff @(posedge clk_g) begin
        if (rst_g) begin
            result.valid    <= 1'b0;
            result.rd_write <= 1'b0;
        end else begin
            result.valid <= uop.valid && !stall;
            // Held while stalled, only valid drops
            if (!stall) begin
                result.rd       <= uop.rd;
                result.rd_write <= rd_write;
                result.rd_value <= rd_value;
            end
        end
    end

endmodule

// File: source/read_execute_stage.sv
module read_execute_stage
    import isa_pkg::*, uop_pkg::*;
#(
    parameter int mul_bits_per_cycle = 2
) (
    input  logic            clk_g,
    input  logic            rst_g,
    input  uop_t            uop,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    output logic [4:0]      rs1_addr,
    output logic [4:0]      rs2_addr,
    output logic            stall,
    output logic            flush,
    output logic [xlen-1:0] next_pc,
    output logic            exception,
    output logic [xlen-1:0] exception_pc,
    output result_t         result
);

    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
    logic [xlen-1:0] alu_value;
    logic            redirect;
    logic [xlen-1:0] target;
    logic [xlen-1:0] link;
    logic            mul_start;
    logic            mul_done;
    logic [xlen-1:0] product;

    // Register file read ports
    assign rs1_addr = uop.rs1;
    assign rs2_addr = uop.rs2;

    operand_select u_operand_select (
        .uop      (uop),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .prev     (result),
        .op1      (op1),
        .op2      (op2)
    );

    alu u_alu (
        .func  (uop.func),
        .op1   (op1),
        .op2   (op2),
        .value (alu_value)
    );

    branch_unit u_branch_unit (
        .func     (uop.func),
        .pc       (uop.pc),
        .imm      (uop.imm),
        .op1      (op1),
        .op2      (op2),
        .redirect (redirect),
        .target   (target),
        .link     (link)
    );

    multiplier #(
        .mul_bits_per_cycle (mul_bits_per_cycle)
    ) u_multiplier (
        .clk_g   (clk_g),
        .rst_g   (rst_g),
        .start   (mul_start),
        .func    (uop.func),
        .op1     (op1),
        .op2     (op2),
        .done    (mul_done),
        .product (product)
    );

    execute_control u_execute_control (
        .clk_g        (clk_g),
        .rst_g        (rst_g),
        .uop          (uop),
        .alu_value    (alu_value),
        .redirect     (redirect),
        .target       (target),
        .link         (link),
        .mul_done     (mul_done),
        .product      (product),
        .mul_start    (mul_start),
        .stall        (stall),
        .flush        (flush),
        .next_pc      (next_pc),
        .exception    (exception),
        .exception_pc (exception_pc),
        .result       (result)
    );

endmodule

// File: verification/exec_model.svh
// Random word, biased towards sign and range corners
function automatic logic [31:0] rand_word();
    case ($urandom_range(7, 0))
        0:       return 32'h0000_0000;
        1:       return 32'hffff_ffff;
        2:       return 32'h8000_0000;
        3:       return $urandom_range(15, 0);
        default: return $urandom;
    endcase
endfunction

function automatic uop_t random_uop(input exec_unit_e unit);
    uop_t u;
    u = '0;
    u.valid = 1'b1;
    u.unit = unit;
    u.rs1 = 5'($urandom_range(31, 0));
    u.rs2 = 5'($urandom_range(31, 0));
    // x0 as destination about one time in eight
    u.rd = ($urandom_range(7, 0) == 0) ? 5'd0 : 5'($urandom_range(31, 1));
    u.imm = rand_word();
    u.pc = $urandom & 32'hffff_fffc;
    case (unit)
        unit_alu: begin
            u.func = func_e'(5'($urandom_range(10, 0)));
            u.op1_sel = op1_sel_e'(2'($urandom_range(2, 0)));
            u.op2_sel = op2_sel_e'(2'($urandom_range(3, 0)));
        end
        unit_branch: begin
            u.func = func_e'(5'($urandom_range(18, 11)));
            u.op1_sel = op1_rs1;
            u.op2_sel = op2_rs2;
            if ($urandom_range(3, 0) == 0) begin
                u.rs2 = u.rs1;
            end
            // Mostly aligned offsets, some that trap
            if ($urandom_range(3, 0) != 0) begin
                u.imm[1:0] = 2'b00;
            end
        end
        default: begin
            u.func = func_e'(5'($urandom_range(22, 19)));
            u.op1_sel = op1_rs1;
            u.op2_sel = ($urandom_range(3, 0) == 0) ? op2_imm : op2_rs2;
        end
    endcase
    return u;
endfunction

function automatic uop_t random_mixed_uop();
    uop_t u;
    case ($urandom_range(9, 0))
        0, 1, 2, 3, 4: u = random_uop(unit_alu);
        5, 6, 7:       u = random_uop(unit_branch);
        default:       u = random_uop(unit_mul);
    endcase
    // Bubble one time in five
    if ($urandom_range(4, 0) == 0) begin
        u.valid = 1'b0;
    end
    return u;
endfunction

function automatic logic signed_less(input logic [31:0] a, input logic [31:0] b);
    return (a[31] != b[31]) ? a[31] : (a < b);
endfunction

function automatic logic [31:0] model_alu(input func_e f, input logic [31:0] a,
                                          input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f)
        func_add:      return a + b;
        func_sub:      return a + ~b + 32'd1;
        func_sll:      return a << sh;
        func_slt:      return {31'd0, signed_less(a, b)};
        func_sltu:     return {31'd0, a < b};
        func_xor:      return a ^ b;
        func_srl:      return a >> sh;
        // Arithmetic shift from a logical one
        func_sra:      return a[31] ? ~(~a >> sh) : a >> sh;
        func_or:       return a | b;
        func_and:      return a & b;
        func_pass_op2: return b;
        default:       return 32'd0;
    endcase
endfunction

function automatic logic model_taken(input func_e f, input logic [31:0] a,
                                     input logic [31:0] b);
    case (f)
        func_beq:            return a == b;
        func_bne:            return a != b;
        func_blt:            return signed_less(a, b);
        func_bge:            return !signed_less(a, b);
        func_bltu:           return a < b;
        func_bgeu:           return a >= b;
        func_jal, func_jalr: return 1'b1;
        default:             return 1'b0;
    endcase
endfunction

function automatic logic [31:0] model_target(input func_e f, input logic [31:0] pc,
                                             input logic [31:0] imm, input logic [31:0] a);
    return (f == func_jalr) ? ((a + imm) & 32'hffff_fffe) : pc + imm;
endfunction

// Full 64-bit product of the extended operands, then pick a word
function automatic logic [31:0] model_mul(input func_e f, input logic [31:0] a,
                                          input logic [31:0] b);
    logic [63:0] xa;
    logic [63:0] xb;
    logic [63:0] p;
    xa = (f == func_mulh || f == func_mulhsu) ? {{32{a[31]}}, a} : {32'd0, a};
    xb = (f == func_mulh) ? {{32{b[31]}}, b} : {32'd0, b};
    p = xa * xb;
    return (f == func_mul) ? p[31:0] : p[63:32];
endfunction

// File: verification/tb_read_execute_stage.sv
module tb_read_execute_stage
    import isa_pkg::*, uop_pkg::*;
();

    localparam int mul_bits_per_cycle = 2;
    localparam int mul_cycles = xlen / mul_bits_per_cycle;
    localparam int stall_limit = 4 * mul_cycles;

    logic            clk_g;
    logic            rst_g;
    uop_t            uop;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic            stall;
    logic            flush;
    logic [xlen-1:0] next_pc;
    logic            exception;
    logic [xlen-1:0] exception_pc;
    result_t         result;

    logic [31:0] rf [32];
    logic [31:0] arch_regs [32];
    logic [31:0] corners [5];
    int          checks;
    int          errors;
    int          tests_run;
    int          mark_checks;
    int          mark_errors;
    logic        timed_out;
    int          obs_stall_cycles;
    logic        obs_flush;
    logic        obs_exception;
    logic [31:0] obs_next_pc;
    logic [31:0] obs_exception_pc;
    result_t     obs_result;

    read_execute_stage #(
        .mul_bits_per_cycle (mul_bits_per_cycle)
    ) u_read_execute_stage (
        .clk_g        (clk_g),
        .rst_g        (rst_g),
        .uop          (uop),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .stall        (stall),
        .flush        (flush),
        .next_pc      (next_pc),
        .exception    (exception),
        .exception_pc (exception_pc),
        .result       (result)
    );

    initial begin
        clk_g = 1'b0;
        forever #50 clk_g = ~clk_g;
    end

    // Register file seen by the DUT and written back one cycle late
    assign rs1_data = rf[rs1_addr];
    assign rs2_data = rf[rs2_addr];

    always @(posedge clk_g) begin
        if (rst_g) begin
            for (int i = 0; i < 32; i++) begin
                rf[i] <= arch_regs[i];
            end
        end else if (result.valid && result.rd_write && result.rd != 5'd0) begin
            rf[result.rd] <= result.rd_value;
        end
    end

    `include "exec_model.svh"

    //////////////////////////////////////////////////////////////////////////
    // Checking helpers
    //////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_value(name, {31'd0, got}, {31'd0, exp});
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, checks - mark_checks,
                 errors - mark_errors);
        tests_run++;
        mark_checks = checks;
        mark_errors = errors;
    endtask

    function automatic logic [31:0] operand1(input uop_t u);
        case (u.op1_sel)
            op1_rs1: return arch_regs[u.rs1];
            op1_pc:  return u.pc;
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] operand2(input uop_t u);
        case (u.op2_sel)
            op2_rs2:  return arch_regs[u.rs2];
            op2_imm:  return u.imm;
            op2_four: return 32'd4;
            default:  return 32'd0;
        endcase
    endfunction

    // Called at edge plus 10 and returns at edge plus 10 after acceptance
    task automatic issue(input uop_t u);
        uop = u;
        obs_stall_cycles = 0;
        #40;
        while (stall === 1'b1 && obs_stall_cycles <= stall_limit) begin
            obs_stall_cycles++;
            @(posedge clk_g);
            #50;
        end
        assert (obs_stall_cycles <= stall_limit) else begin
            $display("stall still high after %0d cycles, multiply never finished",
                     stall_limit);
            errors++;
            timed_out = 1'b1;
        end
        obs_flush = flush;
        obs_exception = exception;
        obs_next_pc = next_pc;
        obs_exception_pc = exception_pc;
        @(posedge clk_g);
        #10;
        obs_result = result;
    endtask

    task automatic run_and_check(input uop_t u);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] target;
        logic [31:0] exp_value;
        logic        taken;
        logic        exp_write;
        logic        exp_exc;
        int          exp_stall;
        a = operand1(u);
        b = operand2(u);
        target = model_target(u.func, u.pc, u.imm, a);
        taken = 1'b0;
        exp_write = 1'b1;
        exp_stall = 0;
        case (u.unit)
            unit_alu: exp_value = model_alu(u.func, a, b);
            unit_branch: begin
                taken = model_taken(u.func, a, b);
                exp_write = (u.func == func_jal) || (u.func == func_jalr);
                exp_value = u.pc + 32'd4;
            end
            default: begin
                exp_value = model_mul(u.func, a, b);
                exp_stall = mul_cycles;
            end
        endcase
        if (!u.valid) begin
            taken = 1'b0;
            exp_stall = 0;
        end
        exp_exc = taken && (target[1:0] != 2'b00);
        issue(u);
        if (!timed_out) begin
            // Micro-op is still on the input here
            check_value("rs1_addr", {27'd0, rs1_addr}, {27'd0, u.rs1});
            check_value("rs2_addr", {27'd0, rs2_addr}, {27'd0, u.rs2});
            check_value("stall cycles", obs_stall_cycles, exp_stall);
            check_flag("result.valid", obs_result.valid, u.valid);
            check_flag("flush", obs_flush, taken);
            check_flag("exception", obs_exception, exp_exc);
            check_value("next_pc", obs_next_pc, (taken && !exp_exc) ? target : u.pc);
            if (exp_exc) begin
                check_value("exception_pc", obs_exception_pc, target);
            end
            if (u.valid) begin
                check_value("result.rd", {27'd0, obs_result.rd}, {27'd0, u.rd});
                check_flag("result.rd_write", obs_result.rd_write, exp_write);
                if (exp_write) begin
                    check_value("result.rd_value", obs_result.rd_value, exp_value);
                end
                if (exp_write && u.rd != 5'd0) begin
                    arch_regs[u.rd] = exp_value;
                end
            end
        end
    endtask

    // LUI style load through the ALU
    task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
        uop_t u;
        u = random_uop(unit_alu);
        u.func = func_pass_op2;
        u.op2_sel = op2_imm;
        u.imm = value;
        u.rd = rd;
        run_and_check(u);
    endtask

    //////////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////////

    initial begin
        uop_t       u;
        logic [4:0] prev_rd;
        void'($urandom(32'h48af_c857));
        rst_g = 1'b1;
        uop = '0;
        timed_out = 1'b0;
        checks = 0;
        errors = 0;
        tests_run = 0;
        mark_checks = 0;
        mark_errors = 0;
        corners = '{32'h0000_0000, 32'h0000_0001, 32'h7fff_ffff, 32'h8000_0000,
                    32'hffff_ffff};
        arch_regs[0] = 32'd0;
        for (int i = 1; i < 32; i++) begin
            arch_regs[i] = $urandom;
        end
        // Valid ALU traffic while reset is held
        uop = random_uop(unit_alu);
        repeat (10) @(posedge clk_g);
        #10;
        rst_g = 1'b0;
        uop = '0;

        check_flag("result.valid", result.valid, 1'b0);
        check_flag("stall", stall, 1'b0);
        check_flag("flush", flush, 1'b0);
        check_flag("exception", exception, 1'b0);
        end_test("reset");

        for (int i = 0; i < 400 && !timed_out; i++) begin
            run_and_check(random_uop(unit_alu));
        end
        end_test("alu");

        // Each link reads the rd just written, so the register file is stale
        for (int c = 0; c < 25 && !timed_out; c++) begin
            prev_rd = 5'($urandom_range(31, 1));
            for (int k = 0; k < 8 && !timed_out; k++) begin
                u = random_uop(unit_alu);
                u.op1_sel = op1_rs1;
                u.rs1 = prev_rd;
                if ($urandom_range(1, 0) == 1) begin
                    u.op2_sel = op2_rs2;
                    u.rs2 = prev_rd;
                end
                run_and_check(u);
                prev_rd = u.rd;
            end
        end
        end_test("forwarding");

        for (int i = 0; i < 300 && !timed_out; i++) begin
            run_and_check(random_uop(unit_branch));
        end
        end_test("branch");

        for (int f = 0; f < 4 && !timed_out; f++) begin
            for (int i = 0; i < 5 && !timed_out; i++) begin
                for (int j = 0; j < 5 && !timed_out; j++) begin
                    load_reg(5'd1, corners[i]);
                    load_reg(5'd2, corners[j]);
                    u = random_uop(unit_mul);
                    u.func = func_e'(5'(int'(func_mul) + f));
                    u.op2_sel = op2_rs2;
                    u.rs1 = 5'd1;
                    u.rs2 = 5'd2;
                    run_and_check(u);
                end
            end
        end
        for (int i = 0; i < 60 && !timed_out; i++) begin
            run_and_check(random_uop(unit_mul));
        end
        end_test("multiply");

        for (int i = 0; i < 400 && !timed_out; i++) begin
            run_and_check(random_mixed_uop());
        end
        end_test("mixed");

        $display("totals: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: read_execute_stage.f
+incdir+verification
source/isa_pkg.sv
source/uop_pkg.sv
source/operand_select.sv
source/alu.sv
source/branch_unit.sv
source/multiplier.sv
source/execute_control.sv
source/read_execute_stage.sv
verification/tb_read_execute_stage.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert \
    --top-module tb_read_execute_stage \
    -f read_execute_stage.f || exit 1
out=$(./obj_dir/Vtb_read_execute_stage)
echo "$out"
echo "$out" | grep -qx "Regression passed" && exit 0 || exit 1
